//--- source/nandReadPagePkg.sv
package nandReadPagePkg;

    localparam int NumberOfWays = 4;

    typedef logic [5:0]              opcodeT;
    typedef logic [4:0]              targetIdT;
    typedef logic [NumberOfWays-1:0] wayMaskT;
    typedef logic [15:0]             colAddressT;
    typedef logic [23:0]             rowAddressT;
    typedef logic [15:0]             dataLengthT;
    // one-hot, one bit per primitive
    typedef logic [7:0]              primSelectT;
    // first byte on the bus sits in bits 39:32
    typedef logic [39:0]             caDataT;

    localparam opcodeT     ReadPageOpcode   = 6'b000100;
    localparam logic [7:0] ReadCmd1         = 8'h00;
    localparam logic [7:0] ReadCmd2         = 8'h30;
    localparam logic [7:0] ReadParamCmd     = 8'hEC;
    localparam dataLengthT AddressByteCount = 16'd4;
    // low targetId bits for a parameter page read
    localparam logic [1:0] ParamReadSel     = 2'b01;

    // primitive positions in the select word
    localparam int CapsBit   = 3;
    localparam int DataInBit = 1;

    typedef enum logic [2:0] {
        Idle,
        Latch,
        CmdIssue,
        AddrIssue,
        Cmd2Issue,
        WaitBusy,
        WaitReady,
        DataIssue
    } readPageStateT;

    typedef struct packed {
        opcodeT     opcode;
        targetIdT   targetId;
        wayMaskT    waySelect;
        colAddressT colAddress;
        rowAddressT rowAddress;
        dataLengthT length;
    } readRequestT;

    typedef struct packed {
        primSelectT primSelect;
        wayMaskT    targetWay;
        dataLengthT numOfData;
        logic       caSelect;
        caDataT     caData;
    } acgRequestT;

endpackage

//--- source/readPageSequencer.sv
`timescale 1ns/1ns

module readPageSequencer
    import nandReadPagePkg::*;
(
    input  logic          iSystemClock,
    input  logic          reset,
    input  logic          cmdValid,
    input  opcodeT        opcode,
    input  logic          paramRead,
    input  primSelectT    acgLastStep,
    input  logic          wayReady,
    output readPageStateT nextState,
    output logic          cmdReady,
    output logic          lastStep
);

    readPageStateT state;
    logic          accept;
    logic          capsDone;
    logic          dataInDone;

    // only read-page requests are taken, others are ignored
    assign accept = (state == Idle) && cmdValid && cmdReady && (opcode == ReadPageOpcode);

    // completion of the command/address and data-in primitives
    assign capsDone   = acgLastStep[CapsBit];
    assign dataInDone = acgLastStep[DataInBit];

    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (accept) begin
                    nextState = Latch;
                end
            end
            Latch: begin
                nextState = CmdIssue;
            end
            CmdIssue: begin
                if (capsDone) begin
                    nextState = AddrIssue;
                end
            end
            AddrIssue: begin
                // parameter page has no second command
                if (capsDone) begin
                    nextState = paramRead ? WaitBusy : Cmd2Issue;
                end
            end
            Cmd2Issue: begin
                if (capsDone) begin
                    nextState = WaitBusy;
                end
            end
            WaitBusy: begin
                // target goes busy once the array read starts
                if (!wayReady) begin
                    nextState = WaitReady;
                end
            end
            WaitReady: begin
                if (wayReady) begin
                    nextState = DataIssue;
                end
            end
            DataIssue: begin
                if (dataInDone) begin
                    nextState = Idle;
                end
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    // lastStep trails the data-in completion by one cycle,
    // cmdReady comes back one cycle after that
    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            cmdReady <= 1'b1;
            lastStep <= 1'b0;
        end else begin
            lastStep <= (state == DataIssue) && dataInDone;
            if (accept) begin
                cmdReady <= 1'b0;
            end else if (lastStep) begin
                cmdReady <= 1'b1;
            end
        end
    end

endmodule

//--- source/commandAddressFormatter.sv
`timescale 1ns/1ns

module commandAddressFormatter
    import nandReadPagePkg::*;
(
    input  logic          iSystemClock,
    input  logic          reset,
    input  readRequestT   request,
    input  readPageStateT nextState,
    output logic          paramRead,
    output acgRequestT    acg
);

    targetIdT   latchedTargetId;
    colAddressT latchedCol;
    rowAddressT latchedRow;
    dataLengthT latchedLength;
    acgRequestT acgNext;

    // request fields held for the whole sequence
    always_ff @(posedge iSystemClock) begin
        if (nextState == Latch) begin
            latchedTargetId <= request.targetId;
            latchedCol      <= request.colAddress;
            latchedRow      <= request.rowAddress;
            latchedLength   <= request.length;
        end
    end

    assign paramRead = (latchedTargetId[1:0] == ParamReadSel);

    always_comb begin
        // idle word, way mask held
        acgNext.primSelect = '0;
        acgNext.targetWay  = acg.targetWay;
        acgNext.numOfData  = '0;
        acgNext.caSelect   = 1'b1;
        acgNext.caData     = '0;
        case (nextState)
            Idle, Latch: begin
                // way tracks the host until the request is taken
                acgNext.targetWay = ~request.waySelect;
            end
            CmdIssue: begin
                acgNext.primSelect[CapsBit] = 1'b1;
                acgNext.caData = {paramRead ? ReadParamCmd : ReadCmd1, 32'h0};
            end
            AddrIssue: begin
                acgNext.primSelect[CapsBit] = 1'b1;
                acgNext.caSelect = 1'b0;
                if (!paramRead) begin
                    acgNext.numOfData = AddressByteCount;
                    // column bytes first, low byte leading
                    acgNext.caData = {latchedCol[7:0], latchedCol[15:8],
                                      latchedRow[7:0], latchedRow[15:8], latchedRow[23:16]};
                end
            end
            Cmd2Issue: begin
                acgNext.primSelect[CapsBit] = 1'b1;
                acgNext.caData = {ReadCmd2, 32'h0};
            end
            DataIssue: begin
                acgNext.primSelect[DataInBit] = 1'b1;
                acgNext.caSelect  = 1'b0;
                acgNext.numOfData = latchedLength;
            end
            default: begin
                acgNext.primSelect = '0;
            end
        endcase
    end

    // registered from nextState so the word lines up with the state
    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            acg.primSelect <= '0;
            acg.targetWay  <= '1;
            acg.numOfData  <= '0;
            acg.caSelect   <= 1'b1;
            acg.caData     <= '0;
        end else begin
            acg <= acgNext;
        end
    end

endmodule

//--- source/readyBusyMonitor.sv
`timescale 1ns/1ns

module readyBusyMonitor
    import nandReadPagePkg::*;
(
    input  logic    iSystemClock,
    input  logic    reset,
    input  wayMaskT targetWay,
    input  wayMaskT readyBusy,
    output logic    wayReady
);

    wayMaskT targetMask;
    wayMaskT pinSample;
    wayMaskT maskedPins;

    // three stages, a new pin sample enters every cycle
    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            targetMask <= '0;
            pinSample  <= '0;
            maskedPins <= '0;
            wayReady   <= 1'b0;
        end else begin
            // targetWay is active low
            targetMask <= ~targetWay;
            pinSample  <= readyBusy;
            maskedPins <= targetMask & pinSample;
            wayReady   <= |maskedPins;
        end
    end

endmodule

//--- source/nandReadPageTop.sv
`timescale 1ns/1ns

module nandReadPageTop
    import nandReadPagePkg::*;
(
    input  logic        iSystemClock,
    input  logic        reset,
    input  readRequestT request,
    input  logic        cmdValid,
    output logic        cmdReady,
    output logic        lastStep,
    output acgRequestT  acg,
    input  primSelectT  acgLastStep,
    input  wayMaskT     readyBusy
);

    readPageStateT nextState;
    logic          paramRead;
    logic          wayReady;

    // phase control and host handshake
    readPageSequencer readPageSequencer_i (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .cmdValid     (cmdValid),
        .opcode       (request.opcode),
        .paramRead    (paramRead),
        .acgLastStep  (acgLastStep),
        .wayReady     (wayReady),
        .nextState    (nextState),
        .cmdReady     (cmdReady),
        .lastStep     (lastStep)
    );

    // primitive request word per phase
    commandAddressFormatter commandAddressFormatter_i (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .request      (request),
        .nextState    (nextState),
        .paramRead    (paramRead),
        .acg          (acg)
    );

    // ready/busy of the selected way only
    readyBusyMonitor readyBusyMonitor_i (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .targetWay    (acg.targetWay),
        .readyBusy    (readyBusy),
        .wayReady     (wayReady)
    );

endmodule

//--- tests/nandReadPage_chk.sv
`timescale 1ns/1ns

module nandReadPageChk
    import nandReadPagePkg::*;
(
    input logic       iSystemClock,
    input logic       reset,
    input logic       cmdReady,
    input logic       lastStep,
    input acgRequestT acg
);

    // at most one primitive requested at a time
    primOneHot: assert property (@(posedge iSystemClock) disable iff (reset)
        $onehot0(acg.primSelect))
        else $error("more than one primitive selected");

    // completion is a single-cycle pulse
    lastStepPulse: assert property (@(posedge iSystemClock) disable iff (reset)
        lastStep |=> !lastStep)
        else $error("lastStep held longer than one cycle");

    // host port closed while a primitive is pending
    readyWhileBusy: assert property (@(posedge iSystemClock) disable iff (reset)
        (acg.primSelect != '0) |-> !cmdReady)
        else $error("cmdReady high while a primitive request is active");

    // port reopens right after completion
    readyAfterDone: assert property (@(posedge iSystemClock) disable iff (reset)
        lastStep |=> cmdReady)
        else $error("cmdReady not back after lastStep");

endmodule

bind nandReadPageTop nandReadPageChk nandReadPageChk_i (
    .iSystemClock (iSystemClock),
    .reset        (reset),
    .cmdReady     (cmdReady),
    .lastStep     (lastStep),
    .acg          (acg)
);

//--- tests/nandReadPageTb.sv
`timescale 1ns/1ns

module nandReadPageTb
    import nandReadPagePkg::*;
();

    localparam int         MaxVectors       = 32;
    localparam int         IgnoreCycles     = 6;
    localparam int         MarginPerRequest = 40;
    localparam opcodeT     ReadPageCode     = 6'b000100;
    localparam logic [7:0] SecondCommand    = 8'h30;
    localparam dataLengthT AddressCount     = 16'd4;
    localparam primSelectT CapsSelect       = 8'b0000_1000;
    localparam primSelectT DataInSelect     = 8'b0000_0010;

    // one line of the data file
    typedef struct packed {
        logic [7:0]  opcode;
        logic [7:0]  targetId;
        wayMaskT     way;
        colAddressT  col;
        rowAddressT  row;
        dataLengthT  length;
        logic [7:0]  stepDelay;
        logic [7:0]  busyTime;
        logic [7:0]  readyTime;
        logic [7:0]  expCmd;
        caDataT      expAddr;
    } vectorT;

    logic        iSystemClock;
    logic        reset;
    readRequestT request;
    logic        cmdValid;
    logic        cmdReady;
    logic        lastStep;
    acgRequestT  acg;
    primSelectT  acgLastStep;
    wayMaskT     readyBusy;

    logic [$bits(vectorT)-1:0] rawVectors [MaxVectors];
    int vectorCount;
    int readCount;
    int pulseCount;
    int cycleCount;
    int cycleLimit;

    nandReadPageTop nandReadPageTop_i (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .request      (request),
        .cmdValid     (cmdValid),
        .cmdReady     (cmdReady),
        .lastStep     (lastStep),
        .acg          (acg),
        .acgLastStep  (acgLastStep),
        .readyBusy    (readyBusy)
    );

    initial begin
        iSystemClock = 1'b0;
        forever #20 iSystemClock = ~iSystemClock;
    end

    always @(posedge iSystemClock) begin
        if (reset) begin
            pulseCount <= 0;
        end else if (lastStep) begin
            pulseCount <= pulseCount + 1;
        end
    end

    // run limit from the delays in the data file
    always @(posedge iSystemClock) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("run did not finish within %0d cycles", cycleLimit);
            failRun();
        end
    end

    task automatic failRun();
        $display("test failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic expectEqual(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        assert (got === expected) else begin
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, what, got, expected);
            failRun();
        end
    endtask

    function automatic readRequestT toRequest(input vectorT v);
        readRequestT r;
        r.opcode     = v.opcode[5:0];
        r.targetId   = v.targetId[4:0];
        r.waySelect  = v.way;
        r.colAddress = v.col;
        r.rowAddress = v.row;
        r.length     = v.length;
        return r;
    endfunction

    task automatic loadVectors();
        vectorT v;
        // all ones marks an unused entry
        for (int i = 0; i < MaxVectors; i++) begin
            rawVectors[i] = '1;
        end
        $readmemh("tests/nandReadPage_input.txt", rawVectors);
        vectorCount = 0;
        while (vectorCount < MaxVectors && rawVectors[vectorCount] != '1) begin
            vectorCount++;
        end
        assert (vectorCount > 0) else begin
            $display("no stimulus lines were read from the data file");
            failRun();
        end
        cycleLimit = 20;
        for (int i = 0; i < vectorCount; i++) begin
            v = rawVectors[i];
            cycleLimit += 4 * int'(v.stepDelay) + int'(v.busyTime) + int'(v.readyTime);
            cycleLimit += MarginPerRequest;
        end
    endtask

    // primitive generator model answering with lastStep after the delay
    task automatic answerPrimitive(input primSelectT select, input int delay);
        acgRequestT held;
        held = acg;
        repeat (delay) begin
            @(negedge iSystemClock);
            assert (acg === held) else begin
                $display("[FAIL] %0t primitive request changed before its last step", $time);
                failRun();
            end
        end
        @(posedge iSystemClock);
        acgLastStep <= select;
        @(posedge iSystemClock);
        acgLastStep <= '0;
        @(negedge iSystemClock);
    endtask

    task automatic expectNoPrimitive(input int cycles);
        repeat (cycles) begin
            @(negedge iSystemClock);
            expectEqual("select before way ready", 64'(acg.primSelect), 64'd0);
        end
    endtask

    task automatic runReadPage(input vectorT v);
        logic    paramPage;
        wayMaskT expWay;
        paramPage = (v.targetId[1:0] == 2'b01);
        expWay    = ~v.way;
        readCount++;
        @(posedge iSystemClock);
        request   <= toRequest(v);
        cmdValid  <= 1'b1;
        readyBusy <= '1;
        // cmdReady is high in idle, so this edge takes the request
        @(posedge iSystemClock);
        cmdValid <= 1'b0;
        // inverted fields from here on so only the latched request can match
        request  <= ~toRequest(v);
        @(negedge iSystemClock);
        expectEqual("cmdReady after acceptance", 64'(cmdReady), 64'd0);
        expectEqual("select in latch cycle", 64'(acg.primSelect), 64'd0);
        @(negedge iSystemClock);
        expectEqual("command select", 64'(acg.primSelect), 64'(CapsSelect));
        expectEqual("command caSelect", 64'(acg.caSelect), 64'd1);
        expectEqual("command byte", 64'(acg.caData[39:32]), 64'(v.expCmd));
        answerPrimitive(CapsSelect, int'(v.stepDelay));
        expectEqual("address select", 64'(acg.primSelect), 64'(CapsSelect));
        expectEqual("address caSelect", 64'(acg.caSelect), 64'd0);
        expectEqual("address word", 64'(acg.caData), 64'(v.expAddr));
        expectEqual("address count", 64'(acg.numOfData),
                    paramPage ? 64'd0 : 64'(AddressCount));
        answerPrimitive(CapsSelect, int'(v.stepDelay));
        if (!paramPage) begin
            expectEqual("second command select", 64'(acg.primSelect), 64'(CapsSelect));
            expectEqual("second command caSelect", 64'(acg.caSelect), 64'd1);
            expectEqual("second command byte", 64'(acg.caData[39:32]), 64'(SecondCommand));
            answerPrimitive(CapsSelect, int'(v.stepDelay));
        end
        expectEqual("select while waiting", 64'(acg.primSelect), 64'd0);
        // flash model goes busy after the ready time and back after the busy time
        expectNoPrimitive(int'(v.readyTime));
        @(posedge iSystemClock);
        readyBusy <= ~v.way;
        expectNoPrimitive(int'(v.busyTime));
        // the other ways stay busy while the selected one recovers
        @(posedge iSystemClock);
        readyBusy <= v.way;
        @(negedge iSystemClock);
        while (acg.primSelect == '0) begin
            @(negedge iSystemClock);
        end
        expectEqual("data-in select", 64'(acg.primSelect), 64'(DataInSelect));
        expectEqual("data-in length", 64'(acg.numOfData), 64'(v.length));
        expectEqual("data-in targetWay", 64'(acg.targetWay), 64'(expWay));
        expectEqual("data-in caSelect", 64'(acg.caSelect), 64'd0);
        answerPrimitive(DataInSelect, int'(v.stepDelay));
        expectEqual("lastStep after data-in", 64'(lastStep), 64'd1);
        expectEqual("select after data-in", 64'(acg.primSelect), 64'd0);
        @(negedge iSystemClock);
        expectEqual("lastStep one cycle later", 64'(lastStep), 64'd0);
        expectEqual("cmdReady after completion", 64'(cmdReady), 64'd1);
        expectEqual("lastStep pulse count", 64'(pulseCount), 64'(readCount));
    endtask

    // other opcodes must be ignored entirely
    task automatic runIgnoredRequest(input vectorT v);
        @(posedge iSystemClock);
        request  <= toRequest(v);
        cmdValid <= 1'b1;
        repeat (IgnoreCycles) begin
            @(negedge iSystemClock);
            expectEqual("cmdReady with other opcode", 64'(cmdReady), 64'd1);
            expectEqual("select with other opcode", 64'(acg.primSelect), 64'd0);
        end
        @(posedge iSystemClock);
        cmdValid <= 1'b0;
        @(negedge iSystemClock);
        expectEqual("pulse count with other opcode", 64'(pulseCount), 64'(readCount));
    endtask

    initial begin
        vectorT vec;
        int     gap;
        void'($urandom(32'h2dde));
        reset       <= 1'b1;
        request     <= '0;
        cmdValid    <= 1'b0;
        acgLastStep <= '0;
        readyBusy   <= '1;
        readCount   = 0;
        cycleLimit  = 0;
        loadVectors();
        repeat (3) @(posedge iSystemClock);
        reset <= 1'b0;
        @(negedge iSystemClock);
        expectEqual("cmdReady after reset", 64'(cmdReady), 64'd1);
        expectEqual("lastStep after reset", 64'(lastStep), 64'd0);
        expectEqual("select after reset", 64'(acg.primSelect), 64'd0);
        expectEqual("targetWay after reset", 64'(acg.targetWay), 64'hf);
        expectEqual("caSelect after reset", 64'(acg.caSelect), 64'd1);
        for (int i = 0; i < vectorCount; i++) begin
            vec = rawVectors[i];
            // random idle gap between requests
            gap = $urandom % 4;
            repeat (gap) @(posedge iSystemClock);
            if (vec.opcode[5:0] == ReadPageCode) begin
                runReadPage(vec);
            end else begin
                runIgnoredRequest(vec);
            end
        end
        if (pulseCount == readCount) begin
            $display("test passed");
            $finish;
        end else begin
            $display("[FAIL] %0t %0d lastStep pulses for %0d requests",
                     $time, pulseCount, readCount);
            failRun();
        end
    end

endmodule

//--- tests/nandReadPage_input.txt
// read-page requests, one per line, hex fields split by underscores
// opcode_targetId_way_column_row_length_stepDelay_busy_ready_expCmd_expAddress
// delays in cycles, expAddress is the 40-bit word with the first bus byte leading
04_00_1_1234_abcdef_0200_02_06_01_00_3412efcdab
04_02_2_0000_000000_0010_00_01_00_00_0000000000
04_01_4_5678_123456_0100_01_08_02_ec_0000000000
3f_00_1_1111_111111_0001_00_00_00_00_0000000000
04_1d_8_ffff_fedcba_1000_05_0c_03_ec_0000000000
04_13_8_8001_00a5c3_0800_03_03_00_00_0180c3a500
05_00_2_2222_222222_0002_00_00_00_00_0000000000
04_05_2_00ff_0001ff_0004_04_02_04_ec_0000000000
04_0a_4_abcd_0f1e2d_0020_00_0a_01_00_cdab2d1e0f
00_01_1_3333_333333_0003_00_00_00_00_0000000000
04_1f_1_4321_765432_0002_02_01_00_00_2143325476
04_00_2_0100_020304_ffff_01_05_02_00_0001040302
04_09_8_1357_9bdf02_0040_03_04_01_ec_0000000000
04_04_4_2468_ace135_0003_01_07_03_00_682435e1ac
24_00_1_4444_444444_0004_00_00_00_00_0000000000
04_0e_2_fedc_ba9876_0080_00_02_00_00_dcfe7698ba

//--- src.f
source/nandReadPagePkg.sv
source/readPageSequencer.sv
source/commandAddressFormatter.sv
source/readyBusyMonitor.sv
source/nandReadPageTop.sv
tests/nandReadPage_chk.sv
tests/nandReadPageTb.sv

//--- run.sh
#!/bin/sh
# build the testbench and DUT with Verilator, then run the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module nandReadPageTb \
    -f src.f

# exit status of the simulation is the test result
./obj_dir/VnandReadPageTb
